// File: dbg_mem_system.f
verilog/dm_pkg.sv
verilog/debug_cmd_decoder.sv
verilog/wb2axi.sv
verilog/axi_mem.sv
verilog/dbg_mem_system.sv
tb/tb_dbg_mem_system.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dbg_mem_system \
   -f dbg_mem_system.f \
   -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
   echo "Testbench reported a failure"
   exit 1
fi
exit 0

// File: tb/tb_dbg_mem_system.sv
/*
 * Directed testbench for the debug-attached memory tile.
 * Sends command packets on the debug link, checks every response word
 * against a reference word memory and prints one line per test.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_dbg_mem_system;

   localparam int MEM_WORDS = 1024;
   localparam logic [1:0] OP_READ  = 2'd1;
   localparam logic [1:0] OP_WRITE = 2'd2;
   // About 100 commands, none longer than 60 cycles with stalls
   localparam int MAX_CYCLES = 100 * 60;

   logic        clk_i;
   logic        arst_n_i;
   logic [15:0] dbg_in_data_i;
   logic        dbg_in_valid_i;
   logic        dbg_in_ready_o;
   logic [15:0] dbg_out_data_o;
   logic        dbg_out_valid_o;
   logic        dbg_out_ready_i;

   // Reference memory and the word indices written so far
   logic [31:0] model_mem [MEM_WORDS];
   bit          model_set [MEM_WORDS];
   int          written[$];

   bit          stall_en;
   int          cycles;
   int          check_count;
   int          fail_count;

   dbg_mem_system #(
      .ADDR_WIDTH (28),
      .MEM_WORDS  (MEM_WORDS)
   ) i_dut (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .dbg_in_data_i   (dbg_in_data_i),
      .dbg_in_valid_i  (dbg_in_valid_i),
      .dbg_in_ready_o  (dbg_in_ready_o),
      .dbg_out_data_o  (dbg_out_data_o),
      .dbg_out_valid_o (dbg_out_valid_o),
      .dbg_out_ready_i (dbg_out_ready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // Watchdog on the whole run
   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Timeout after %0d cycles, a link handshake never completed", cycles);
      $display("sim failed");
      $finish;
   end

   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] got);
      check_count++;
      assert (got === exp) else begin
         fail_count++;
         $display("ERROR %s expected 0x%0h got 0x%0h", name, exp, got);
      end
   endtask

   task automatic check_link_idle();
      check_val("dbg_out_valid_o", 32'h0, {31'h0, dbg_out_valid_o});
      check_val("dbg_in_ready_o", 32'h1, {31'h0, dbg_in_ready_o});
   endtask

   // Entered just after a rising edge, left just after the edge that moved the word
   task automatic send_word(input logic [15:0] word);
      dbg_in_data_i  <= word;
      dbg_in_valid_i <= 1'b1;
      @(negedge clk_i);
      while (!dbg_in_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      dbg_in_valid_i <= 1'b0;
   endtask

   task automatic recv_word(output logic [15:0] word);
      int stall;
      stall = 0;
      if (stall_en) begin
         stall = $urandom % 4;
      end
      if (stall > 0) begin
         // Hold the word back once the DUT offers it
         @(negedge clk_i);
         while (!dbg_out_valid_o) @(negedge clk_i);
         repeat (stall) @(posedge clk_i);
      end
      dbg_out_ready_i <= 1'b1;
      @(negedge clk_i);
      while (!dbg_out_valid_o) @(negedge clk_i);
      word = dbg_out_data_o;
      @(posedge clk_i);
      dbg_out_ready_i <= 1'b0;
   endtask

   // No extra response word and the input is open again
   task automatic check_idle();
      @(negedge clk_i);
      check_link_idle();
      @(posedge clk_i);
   endtask

   task automatic do_write(input logic [27:0] addr, input logic [31:0] data);
      logic [25:0] word_idx;
      logic        exp_err;
      logic [15:0] resp;
      word_idx = addr[27:2];
      exp_err  = (word_idx >= MEM_WORDS);
      send_word({OP_WRITE, 2'b00, addr[27:16]});
      send_word(addr[15:0]);
      send_word(data[31:16]);
      send_word(data[15:0]);
      recv_word(resp);
      check_val("dbg_out_data_o (write header)", {16'h0, OP_WRITE, 13'h0, exp_err},
                {16'h0, resp});
      check_idle();
      if (!exp_err) begin
         if (!model_set[word_idx[9:0]]) begin
            written.push_back(int'(word_idx[9:0]));
         end
         model_mem[word_idx[9:0]] = data;
         model_set[word_idx[9:0]] = 1'b1;
      end
   endtask

   task automatic do_read(input logic [27:0] addr);
      logic [25:0] word_idx;
      logic        exp_err;
      logic [31:0] exp_data;
      logic [15:0] resp;
      logic [15:0] hi;
      logic [15:0] lo;
      word_idx = addr[27:2];
      exp_err  = (word_idx >= MEM_WORDS);
      exp_data = exp_err ? 32'h0 : model_mem[word_idx[9:0]];
      send_word({OP_READ, 2'b00, addr[27:16]});
      send_word(addr[15:0]);
      recv_word(resp);
      recv_word(hi);
      recv_word(lo);
      check_val("dbg_out_data_o (read header)", {16'h0, OP_READ, 13'h0, exp_err},
                {16'h0, resp});
      check_val("dbg_out_data_o (read data)", exp_data, {hi, lo});
      check_idle();
   endtask

   // One-word command with an opcode outside read and write
   task automatic do_bad_op(input logic [1:0] op);
      logic [15:0] resp;
      send_word({op, 14'h02a5});
      recv_word(resp);
      check_val("dbg_out_data_o (error header)", {16'h0, op, 13'h0, 1'b1}, {16'h0, resp});
      check_idle();
   endtask

   task automatic report_test(input string name, input int fails_before);
      if (fail_count == fails_before) begin
         $display("Test %s: passed", name);
      end else begin
         $display("Test %s: FAILED with %0d errors", name, fail_count - fails_before);
      end
   endtask

   task automatic test_reset();
      int fails;
      fails = fail_count;
      repeat (5) begin
         @(negedge clk_i);
         check_link_idle();
      end
      @(posedge clk_i);
      arst_n_i <= 1'b1;
      check_idle();
      report_test("reset_state", fails);
   endtask

   task automatic test_write_read();
      int fails;
      fails = fail_count;
      do_write(28'h0000100, 32'hdeadbeef);
      do_read(28'h0000100);
      report_test("write_read", fails);
   endtask

   task automatic run_random(input string name, input bit stall);
      int fails;
      int i;
      int word;
      fails    = fail_count;
      stall_en = stall;
      for (i = 0; i < 40; i++) begin
         if (written.size() == 0 || ($urandom % 2) == 0) begin
            word = $urandom % MEM_WORDS;
            // Low address bits are random and must be ignored
            do_write(28'(word * 4) + 28'($urandom % 4), $urandom);
         end else begin
            word = written[$urandom % written.size()];
            do_read(28'(word * 4) + 28'($urandom % 4));
         end
      end
      stall_en = 1'b0;
      report_test(name, fails);
   endtask

   task automatic test_out_of_range();
      int fails;
      fails = fail_count;
      do_write(28'h0000014, 32'h13579bdf);
      // Word 1029 shares its low index bits with word 5
      do_write(28'h0001014, 32'ha5a5a5a5);
      do_write(28'hffffff0, 32'h5a5a5a5a);
      do_read(28'h0001014);
      do_read(28'hffffffc);
      do_read(28'h0000014);
      report_test("out_of_range", fails);
   endtask

   task automatic test_bad_opcode();
      int fails;
      fails = fail_count;
      do_bad_op(2'd0);
      do_bad_op(2'd3);
      do_read(28'h0000100);
      report_test("bad_opcode", fails);
   endtask

   initial begin
      arst_n_i        = 1'b0;
      dbg_in_data_i   = '0;
      dbg_in_valid_i  = 1'b0;
      dbg_out_ready_i = 1'b0;
      stall_en        = 1'b0;
      check_count     = 0;
      fail_count      = 0;
      void'($urandom(63007));
      test_reset();
      test_write_read();
      run_random("random_traffic", 1'b0);
      test_out_of_range();
      test_bad_opcode();
      run_random("back_pressure", 1'b1);
      $display("Checks: %0d passed, %0d failed", check_count - fail_count, fail_count);
      if (fail_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/axi_mem.sv
/*
 * AXI slave word memory standing in for the DRAM controller.
 * Single-beat accesses only; a word index at or above MEM_WORDS
 * answers SLVERR, drops the write and reads back zero.
 */

`timescale 1ns/100ps
`default_nettype none

module axi_mem #(
   parameter int ADDR_WIDTH = dm_pkg::ADDR_WIDTH,
   parameter int MEM_WORDS  = dm_pkg::MEM_WORDS
) (
   input  wire                   clk_i,
   input  wire                   arst_n_i,

   input  wire [ADDR_WIDTH-1:0]  s_axi_awaddr_i,
   input  wire                   s_axi_awvalid_i,
   output logic                  s_axi_awready_o,
   input  dm_pkg::data_t         s_axi_wdata_i,
   input  wire                   s_axi_wvalid_i,
   output logic                  s_axi_wready_o,
   output logic [1:0]            s_axi_bresp_o,
   output logic                  s_axi_bvalid_o,
   input  wire                   s_axi_bready_i,
   input  wire [ADDR_WIDTH-1:0]  s_axi_araddr_i,
   input  wire                   s_axi_arvalid_i,
   output logic                  s_axi_arready_o,
   output dm_pkg::data_t         s_axi_rdata_o,
   output logic [1:0]            s_axi_rresp_o,
   output logic                  s_axi_rvalid_o,
   input  wire                   s_axi_rready_i
);

   import dm_pkg::*;

   localparam int IDX_WIDTH = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   data_t mem [MEM_WORDS];

   logic [ADDR_WIDTH-3:0] aw_word;
   logic [ADDR_WIDTH-3:0] ar_word;
   logic                  aw_ok;
   logic                  ar_ok;
   logic                  wr_fire;
   logic                  rd_fire;

   // Word index sits above the byte offset
   assign aw_word = s_axi_awaddr_i[ADDR_WIDTH-1:2];
   assign ar_word = s_axi_araddr_i[ADDR_WIDTH-1:2];
   assign aw_ok   = (aw_word < MEM_WORDS);
   assign ar_ok   = (ar_word < MEM_WORDS);

   // AW and W are taken together, and only with no B pending
   assign s_axi_awready_o = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
   assign s_axi_wready_o  = s_axi_awready_o;
   assign s_axi_arready_o = s_axi_arvalid_i && !s_axi_rvalid_o;

   assign wr_fire = s_axi_awready_o;
   assign rd_fire = s_axi_arready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         s_axi_bvalid_o <= 1'b0;
         s_axi_rvalid_o <= 1'b0;
      end else begin
         if (wr_fire) begin
            s_axi_bvalid_o <= 1'b1;
         end else if (s_axi_bready_i) begin
            s_axi_bvalid_o <= 1'b0;
         end
         if (rd_fire) begin
            s_axi_rvalid_o <= 1'b1;
         end else if (s_axi_rready_i) begin
            s_axi_rvalid_o <= 1'b0;
         end
      end
   end

   // Storage and response payload
   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         if (aw_ok) begin
            mem[aw_word[IDX_WIDTH-1:0]] <= s_axi_wdata_i;
            s_axi_bresp_o <= AXI_RESP_OKAY;
         end else begin
            s_axi_bresp_o <= AXI_RESP_SLVERR;
         end
      end
      if (rd_fire) begin
         if (ar_ok) begin
            s_axi_rdata_o <= mem[ar_word[IDX_WIDTH-1:0]];
            s_axi_rresp_o <= AXI_RESP_OKAY;
         end else begin
            s_axi_rdata_o <= '0;
            s_axi_rresp_o <= AXI_RESP_SLVERR;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/dbg_mem_system.sv
/*
 * Debug-attached memory tile. Debug link words are decoded into
 * Wishbone accesses, bridged to AXI and served by the word memory.
 */

`timescale 1ns/100ps
`default_nettype none

module dbg_mem_system #(
   parameter int ADDR_WIDTH = dm_pkg::ADDR_WIDTH,
   parameter int MEM_WORDS  = dm_pkg::MEM_WORDS
) (
   input  wire                clk_i,
   input  wire                arst_n_i,

   input  dm_pkg::link_word_t dbg_in_data_i,
   input  wire                dbg_in_valid_i,
   output logic               dbg_in_ready_o,

   output dm_pkg::link_word_t dbg_out_data_o,
   output logic               dbg_out_valid_o,
   input  wire                dbg_out_ready_i
);

   import dm_pkg::*;

   // Wishbone between decoder and bridge
   logic  wb_cyc;
   logic  wb_stb;
   logic  wb_we;
   addr_t wb_adr;
   data_t wb_dat_w;
   data_t wb_dat_r;
   logic  wb_ack;
   logic  wb_err;

   // AXI between bridge and memory
   logic [ADDR_WIDTH-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   data_t                 wdata;
   logic                  wvalid;
   logic                  wready;
   logic [1:0]            bresp;
   logic                  bvalid;
   logic                  bready;
   logic [ADDR_WIDTH-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   data_t                 rdata;
   logic [1:0]            rresp;
   logic                  rvalid;
   logic                  rready;

   debug_cmd_decoder #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_debug_cmd_decoder (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .dbg_in_data_i   (dbg_in_data_i),
      .dbg_in_valid_i  (dbg_in_valid_i),
      .dbg_in_ready_o  (dbg_in_ready_o),
      .dbg_out_data_o  (dbg_out_data_o),
      .dbg_out_valid_o (dbg_out_valid_o),
      .dbg_out_ready_i (dbg_out_ready_i),
      .wb_cyc_o        (wb_cyc),
      .wb_stb_o        (wb_stb),
      .wb_we_o         (wb_we),
      .wb_adr_o        (wb_adr),
      .wb_dat_o        (wb_dat_w),
      .wb_ack_i        (wb_ack),
      .wb_err_i        (wb_err),
      .wb_dat_i        (wb_dat_r)
   );

   wb2axi #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_wb2axi (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .wb_cyc_i        (wb_cyc),
      .wb_stb_i        (wb_stb),
      .wb_we_i         (wb_we),
      .wb_adr_i        (wb_adr),
      .wb_dat_i        (wb_dat_w),
      .wb_ack_o        (wb_ack),
      .wb_err_o        (wb_err),
      .wb_dat_o        (wb_dat_r),
      .m_axi_awaddr_o  (awaddr),
      .m_axi_awvalid_o (awvalid),
      .m_axi_awready_i (awready),
      .m_axi_wdata_o   (wdata),
      .m_axi_wvalid_o  (wvalid),
      .m_axi_wready_i  (wready),
      .m_axi_bresp_i   (bresp),
      .m_axi_bvalid_i  (bvalid),
      .m_axi_bready_o  (bready),
      .m_axi_araddr_o  (araddr),
      .m_axi_arvalid_o (arvalid),
      .m_axi_arready_i (arready),
      .m_axi_rdata_i   (rdata),
      .m_axi_rresp_i   (rresp),
      .m_axi_rvalid_i  (rvalid),
      .m_axi_rready_o  (rready)
   );

   axi_mem #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) i_axi_mem (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .s_axi_awaddr_i  (awaddr),
      .s_axi_awvalid_i (awvalid),
      .s_axi_awready_o (awready),
      .s_axi_wdata_i   (wdata),
      .s_axi_wvalid_i  (wvalid),
      .s_axi_wready_o  (wready),
      .s_axi_bresp_o   (bresp),
      .s_axi_bvalid_o  (bvalid),
      .s_axi_bready_i  (bready),
      .s_axi_araddr_i  (araddr),
      .s_axi_arvalid_i (arvalid),
      .s_axi_arready_o (arready),
      .s_axi_rdata_o   (rdata),
      .s_axi_rresp_o   (rresp),
      .s_axi_rvalid_o  (rvalid),
      .s_axi_rready_i  (rready)
   );

endmodule

`default_nettype wire

// File: verilog/debug_cmd_decoder.sv
/*
 * Debug command decoder. Collects command packets from the debug link,
 * runs one Wishbone classic access per command and returns the response
 * packet on the outgoing link. One command is in flight at a time.
 */

`timescale 1ns/100ps
`default_nettype none

module debug_cmd_decoder #(
   parameter int ADDR_WIDTH = dm_pkg::ADDR_WIDTH
) (
   input  wire                clk_i,
   input  wire                arst_n_i,

   input  dm_pkg::link_word_t dbg_in_data_i,
   input  wire                dbg_in_valid_i,
   output logic               dbg_in_ready_o,

   output dm_pkg::link_word_t dbg_out_data_o,
   output logic               dbg_out_valid_o,
   input  wire                dbg_out_ready_i,

   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output logic               wb_we_o,
   output dm_pkg::addr_t      wb_adr_o,
   output dm_pkg::data_t      wb_dat_o,
   input  wire                wb_ack_i,
   input  wire                wb_err_i,
   input  dm_pkg::data_t      wb_dat_i
);

   import dm_pkg::*;

   // Address bits carried in the header word
   localparam int HI_BITS = ADDR_WIDTH - LINK_WIDTH;

   typedef enum logic [2:0] {
      HDR,
      ADDR_LO,
      DATA_HI,
      DATA_LO,
      BUS,
      RESP_HDR,
      RESP_HI,
      RESP_LO
   } state_t;

   state_t     state_q;
   dbg_op_t    op_q;
   dbg_op_t    hdr_op;
   logic       err_q;
   logic       in_xfer;
   logic       out_xfer;
   link_word_t resp_hdr;

   logic [HI_BITS-1:0]    adr_hi_q;
   logic [LINK_WIDTH-1:0] adr_lo_q;
   data_t                 wdat_q;
   data_t                 rdat_q;

   assign hdr_op   = dbg_op_t'(dbg_in_data_i[15:14]);
   assign in_xfer  = dbg_in_valid_i & dbg_in_ready_o;
   assign out_xfer = dbg_out_valid_o & dbg_out_ready_i;

   // Input is open only while a packet is being collected
   assign dbg_in_ready_o  = (state_q == HDR) || (state_q == ADDR_LO) ||
                            (state_q == DATA_HI) || (state_q == DATA_LO);
   assign dbg_out_valid_o = (state_q == RESP_HDR) || (state_q == RESP_HI) ||
                            (state_q == RESP_LO);

   // Wishbone request, held until ack or err
   assign wb_cyc_o = (state_q == BUS);
   assign wb_stb_o = (state_q == BUS);
   assign wb_we_o  = (op_q == DBG_OP_WRITE);
   assign wb_dat_o = wdat_q;

   // Accesses are word aligned, low two bits forced to zero
   assign wb_adr_o = addr_t'({adr_hi_q, adr_lo_q[LINK_WIDTH-1:2], 2'b00});

   always_comb begin
      resp_hdr = '0;
      resp_hdr[15:14] = op_q;
      resp_hdr[RESP_ERR_BIT] = err_q;
   end

   always_comb begin
      case (state_q)
         RESP_HI: dbg_out_data_o = rdat_q[DATA_WIDTH-1:LINK_WIDTH];
         RESP_LO: dbg_out_data_o = rdat_q[LINK_WIDTH-1:0];
         default: dbg_out_data_o = resp_hdr;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= HDR;
         op_q    <= DBG_OP_READ;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            HDR: begin
               if (in_xfer) begin
                  op_q <= hdr_op;
                  if (hdr_op == DBG_OP_READ || hdr_op == DBG_OP_WRITE) begin
                     err_q   <= 1'b0;
                     state_q <= ADDR_LO;
                  end else begin
                     // Bad opcode, answer at once without a bus access
                     err_q   <= 1'b1;
                     state_q <= RESP_HDR;
                  end
               end
            end
            ADDR_LO: begin
               if (in_xfer) begin
                  state_q <= (op_q == DBG_OP_WRITE) ? DATA_HI : BUS;
               end
            end
            DATA_HI: begin
               if (in_xfer) begin
                  state_q <= DATA_LO;
               end
            end
            DATA_LO: begin
               if (in_xfer) begin
                  state_q <= BUS;
               end
            end
            BUS: begin
               if (wb_ack_i || wb_err_i) begin
                  err_q   <= wb_err_i;
                  state_q <= RESP_HDR;
               end
            end
            RESP_HDR: begin
               if (out_xfer) begin
                  state_q <= (op_q == DBG_OP_READ) ? RESP_HI : HDR;
               end
            end
            RESP_HI: begin
               if (out_xfer) begin
                  state_q <= RESP_LO;
               end
            end
            RESP_LO: begin
               if (out_xfer) begin
                  state_q <= HDR;
               end
            end
            default: state_q <= HDR;
         endcase
      end
   end

   // Packet fields and read data
   always_ff @(posedge clk_i) begin
      if (in_xfer) begin
         case (state_q)
            HDR:     adr_hi_q <= dbg_in_data_i[HI_BITS-1:0];
            ADDR_LO: adr_lo_q <= dbg_in_data_i;
            DATA_HI: wdat_q[DATA_WIDTH-1:LINK_WIDTH] <= dbg_in_data_i;
            DATA_LO: wdat_q[LINK_WIDTH-1:0] <= dbg_in_data_i;
            default: ;
         endcase
      end
      // Error responses carry zero data
      if (state_q == HDR) begin
         rdat_q <= '0;
      end else if (state_q == BUS && wb_ack_i) begin
         rdat_q <= wb_dat_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/dm_pkg.sv
/*
 * Shared definitions for the debug-attached memory tile.
 * Holds the bus and link widths, the vector types built on them,
 * the debug command opcodes and the response header layout.
 * Modules import it inside their body and use scoped names in headers.
 */

`default_nettype none

package dm_pkg;

   // Widths of the memory path and the debug link
   localparam int ADDR_WIDTH = 28;
   localparam int DATA_WIDTH = 32;
   localparam int LINK_WIDTH = 16;

   // Default memory depth in 32-bit words
   localparam int MEM_WORDS = 1024;

   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [LINK_WIDTH-1:0] link_word_t;

   // Command opcodes, header bits 15:14; 0 and 3 are rejected
   typedef enum logic [1:0] {
      DBG_OP_READ  = 2'd1,
      DBG_OP_WRITE = 2'd2
   } dbg_op_t;

   // Error flag in the response header
   localparam int RESP_ERR_BIT = 0;

   // AXI response codes used on B and R
   localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
   localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: verilog/wb2axi.sv
/*
 * Wishbone classic slave to AXI master bridge.
 * Each access becomes one single-beat AXI write or read; SLVERR on
 * B or R is returned as a one-cycle wb_err instead of wb_ack.
 */

`timescale 1ns/100ps
`default_nettype none

module wb2axi #(
   parameter int ADDR_WIDTH = dm_pkg::ADDR_WIDTH
) (
   input  wire                   clk_i,
   input  wire                   arst_n_i,

   input  wire                   wb_cyc_i,
   input  wire                   wb_stb_i,
   input  wire                   wb_we_i,
   input  dm_pkg::addr_t         wb_adr_i,
   input  dm_pkg::data_t         wb_dat_i,
   output logic                  wb_ack_o,
   output logic                  wb_err_o,
   output dm_pkg::data_t         wb_dat_o,

   output logic [ADDR_WIDTH-1:0] m_axi_awaddr_o,
   output logic                  m_axi_awvalid_o,
   input  wire                   m_axi_awready_i,
   output dm_pkg::data_t         m_axi_wdata_o,
   output logic                  m_axi_wvalid_o,
   input  wire                   m_axi_wready_i,
   input  wire [1:0]             m_axi_bresp_i,
   input  wire                   m_axi_bvalid_i,
   output logic                  m_axi_bready_o,
   output logic [ADDR_WIDTH-1:0] m_axi_araddr_o,
   output logic                  m_axi_arvalid_o,
   input  wire                   m_axi_arready_i,
   input  dm_pkg::data_t         m_axi_rdata_i,
   input  wire [1:0]             m_axi_rresp_i,
   input  wire                   m_axi_rvalid_i,
   output logic                  m_axi_rready_o
);

   import dm_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      WR_REQ,
      WR_RESP,
      RD_REQ,
      RD_RESP,
      DONE
   } state_t;

   state_t                state_q;
   logic                  awvalid_q;
   logic                  wvalid_q;
   logic                  arvalid_q;
   logic                  aw_done;
   logic                  w_done;
   logic                  err_q;
   logic [ADDR_WIDTH-1:0] adr_q;
   data_t                 dat_q;
   data_t                 rdat_q;

   assign m_axi_awaddr_o  = adr_q;
   assign m_axi_araddr_o  = adr_q;
   assign m_axi_wdata_o   = dat_q;
   assign m_axi_awvalid_o = awvalid_q;
   assign m_axi_wvalid_o  = wvalid_q;
   assign m_axi_arvalid_o = arvalid_q;
   assign m_axi_bready_o  = (state_q == WR_RESP);
   assign m_axi_rready_o  = (state_q == RD_RESP);

   assign wb_ack_o = (state_q == DONE) && !err_q;
   assign wb_err_o = (state_q == DONE) && err_q;
   assign wb_dat_o = rdat_q;

   // A channel is finished once accepted, now or earlier
   assign aw_done = m_axi_awready_i || !awvalid_q;
   assign w_done  = m_axi_wready_i || !wvalid_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= IDLE;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         arvalid_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (wb_cyc_i && wb_stb_i) begin
                  if (wb_we_i) begin
                     awvalid_q <= 1'b1;
                     wvalid_q  <= 1'b1;
                     state_q   <= WR_REQ;
                  end else begin
                     arvalid_q <= 1'b1;
                     state_q   <= RD_REQ;
                  end
               end
            end
            WR_REQ: begin
               if (m_axi_awready_i) awvalid_q <= 1'b0;
               if (m_axi_wready_i) wvalid_q <= 1'b0;
               if (aw_done && w_done) state_q <= WR_RESP;
            end
            WR_RESP: begin
               if (m_axi_bvalid_i) state_q <= DONE;
            end
            RD_REQ: begin
               if (m_axi_arready_i) begin
                  arvalid_q <= 1'b0;
                  state_q   <= RD_RESP;
               end
            end
            RD_RESP: begin
               if (m_axi_rvalid_i) state_q <= DONE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Request payload and response capture
   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && wb_cyc_i && wb_stb_i) begin
         adr_q <= wb_adr_i[ADDR_WIDTH-1:0];
         dat_q <= wb_dat_i;
      end
      if (state_q == WR_RESP && m_axi_bvalid_i) begin
         err_q <= (m_axi_bresp_i == AXI_RESP_SLVERR);
      end
      if (state_q == RD_RESP && m_axi_rvalid_i) begin
         err_q  <= (m_axi_rresp_i == AXI_RESP_SLVERR);
         rdat_q <= m_axi_rdata_i;
      end
   end

endmodule

`default_nettype wire
